// ==== flist.f ====
+incdir+include
verilog/cpu_pkg.sv
verilog/cpu_if.sv
verilog/issuer.sv
verilog/rs_station.sv
verilog/ro_buffer.sv
verilog/reg_file.sv
verilog/cpu.sv
test/cpu_assert.sv
test/cpu_tb.sv

// ==== include/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data path
`define CPU_XLEN 32

// architectural register file
`define CPU_REG_COUNT 32
`define CPU_REG_ID_W 5

// reorder buffer, its index doubles as the rename tag
`define CPU_ROB_DEPTH 8
`define CPU_ROB_TAG_W 3

// reservation station
`define CPU_RS_DEPTH 4

`endif

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpu_tb -Mdir obj_dir -o cpu_sim -f flist.f

./obj_dir/cpu_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -qx "Simulation passed" sim.log; then
  echo "run.sh: pass"
  exit 0
fi
echo "run.sh: fail"
exit 1

// ==== test/cpu_assert.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu_assert import cpu_pkg::*; (
  input logic    clk_in,
  input logic    rst_in,
  input logic    inst_valid,
  input logic    inst_ready,
  input logic    rob_alloc,
  input logic    commit_valid,
  input reg_id_t commit_rd,
  input word_t   commit_value
);

  int fail_count = 0;
  // accepted instructions not yet seen on the commit port
  int in_flight;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(rob_alloc) - int'(commit_valid);
    end
  end

  // nothing retires on the first edge out of reset
  idle_after_reset: assert property (@(posedge clk_in) $fell(rst_in) |-> !commit_valid)
    else begin
      fail_count++;
      $error("commit_valid high in the cycle after reset");
    end

  // a commit strobe seen now already freed its ROB entry one edge earlier
  accept_needs_room: assert property (@(posedge clk_in) disable iff (rst_in)
      rob_alloc |-> inst_valid && inst_ready &&
                    (in_flight - int'(commit_valid)) < `CPU_ROB_DEPTH)
    else begin
      fail_count++;
      $error("instruction taken while inst_ready was low or the ROB was full");
    end

  // payload moves only together with a commit strobe
  payload_steady: assert property (@(posedge clk_in) disable iff (rst_in)
      !commit_valid |-> $stable(commit_rd) && $stable(commit_value))
    else begin
      fail_count++;
      $error("commit payload changed without commit_valid");
    end

endmodule

bind cpu cpu_assert assert_checks (
  .clk_in(clk_in),
  .rst_in(rst_in),
  .inst_valid(inst_valid),
  .inst_ready(inst_ready),
  .rob_alloc(rob_alloc),
  .commit_valid(commit_valid),
  .commit_rd(commit_rd),
  .commit_value(commit_value)
);

`default_nettype wire

// ==== test/cpu_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();

  localparam int PERIOD      = 100;
  localparam int N_INST      = 400;
  localparam int BURST_START = 150;
  localparam int BURST_END   = 300;
  localparam int TIMEOUT     = N_INST * `CPU_ROB_DEPTH * PERIOD + 500 * PERIOD;

  logic    clk_in;
  logic    rst_in;
  logic    inst_valid;
  word_t   inst_data;
  logic    inst_ready;
  logic    commit_valid;
  reg_id_t commit_rd;
  word_t   commit_value;

  word_t       model_regs [`CPU_REG_COUNT];
  reg_id_t     exp_rd_q [$];
  word_t       exp_val_q [$];
  int          mismatch_count;
  int          other_count;
  int          sent_count;
  int          commit_count;
  logic        saw_stall;
  logic [31:0] seed;

  cpu dut (
    .clk_in(clk_in),
    .rst_in(rst_in),
    .inst_valid(inst_valid),
    .inst_data(inst_data),
    .inst_ready(inst_ready),
    .commit_valid(commit_valid),
    .commit_rd(commit_rd),
    .commit_value(commit_value)
  );

  always #(PERIOD / 2) clk_in = ~clk_in;

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // x0..x3 most of the time in dense mode, to build dependency chains
  function automatic reg_id_t pick_reg(input logic dense);
    logic [31:0] r;
    r = next_rand();
    if (dense || r[31:30] == 2'b00) begin
      return {3'b000, r[29:28]};
    end
    return r[20:16];
  endfunction

  function automatic word_t make_inst(input logic dense);
    logic [31:0] r;
    logic [31:0] r_imm;
    reg_id_t     rd;
    reg_id_t     rs1;
    reg_id_t     rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    r     = next_rand();
    r_imm = next_rand();
    rd    = pick_reg(dense);
    rs1   = pick_reg(dense);
    rs2   = pick_reg(dense);
    f3    = r[26:24];
    alt   = r[27];
    imm   = r_imm[31:20];
    if (r[31]) begin
      return {(alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, OP};
    end
    if (f3 == 3'd1) begin
      imm = {7'h00, imm[4:0]};
    end else if (f3 == 3'd5) begin
      imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
    end
    return {imm, rs1, f3, rd, OP_IMM};
  endfunction

  // RV32I semantics on the architectural state
  function automatic word_t model_exec(input word_t inst);
    word_t              a;
    word_t              b;
    word_t              result;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               is_imm;
    is_imm = (inst[6:0] == OP_IMM);
    a      = model_regs[inst[19:15]];
    b      = is_imm ? {{20{inst[31]}}, inst[31:20]} : model_regs[inst[24:20]];
    sa     = a;
    sb     = b;
    case (inst[14:12])
      3'd0: result = (!is_imm && inst[30]) ? a - b : a + b;
      3'd1: result = a << b[4:0];
      3'd2: result = (sa < sb) ? 32'd1 : 32'd0;
      3'd3: result = (a < b) ? 32'd1 : 32'd0;
      3'd4: result = a ^ b;
      3'd5: begin
        if (inst[30]) begin
          result = sa >>> b[4:0];
        end else begin
          result = a >> b[4:0];
        end
      end
      3'd6: result = a | b;
      default: result = a & b;
    endcase
    return result;
  endfunction

  task automatic compare_value(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      mismatch_count++;
    end
  endtask

  task automatic accept_inst(input word_t inst);
    reg_id_t rd;
    word_t   value;
    rd    = inst[11:7];
    value = model_exec(inst);
    exp_rd_q.push_back(rd);
    exp_val_q.push_back(value);
    if (rd != '0) begin
      model_regs[rd] = value;
    end
    sent_count++;
  endtask

  always @(posedge clk_in) begin
    if (!rst_in && commit_valid) begin
      commit_count++;
      if (exp_rd_q.size() == 0) begin
        $display("%0t ns: commit of x%0d seen with no instruction pending", $time, commit_rd);
        other_count++;
      end else begin
        compare_value(word_t'(commit_rd), word_t'(exp_rd_q[0]), "commit_rd");
        compare_value(commit_value, exp_val_q[0], "commit_value");
        void'(exp_rd_q.pop_front());
        void'(exp_val_q.pop_front());
      end
    end
  end

  initial begin
    logic [31:0] r;
    logic        dense;
    clk_in         = 1'b0;
    rst_in        <= 1'b1;
    inst_valid    <= 1'b0;
    inst_data     <= '0;
    seed           = 32'h0fd4_ef46;
    mismatch_count = 0;
    other_count    = 0;
    sent_count     = 0;
    commit_count   = 0;
    saw_stall      = 1'b0;
    for (int i = 0; i < `CPU_REG_COUNT; i++) begin
      model_regs[i] = '0;
    end

    repeat (8) @(posedge clk_in);
    rst_in <= 1'b0;
    @(posedge clk_in);
    compare_value(word_t'(commit_valid), 32'd0, "commit_valid after reset");
    compare_value(word_t'(inst_ready), 32'd0, "inst_ready after reset");

    // ADDI x5, x0, -1444 reads x0 straight out of reset
    inst_valid <= 1'b1;
    inst_data  <= {12'ha5c, 5'd0, 3'd0, 5'd5, OP_IMM};

    while (sent_count < N_INST) begin
      @(posedge clk_in);
      dense = (sent_count >= BURST_START && sent_count < BURST_END);
      if (inst_valid && inst_ready) begin
        accept_inst(inst_data);
      end else if (inst_valid && dense) begin
        saw_stall = 1'b1;
      end
      if (!inst_valid || inst_ready) begin
        dense = (sent_count >= BURST_START && sent_count < BURST_END);
        r = next_rand();
        if (sent_count >= N_INST) begin
          inst_valid <= 1'b0;
        end else if (!dense && r[31:30] == 2'b00) begin
          inst_valid <= 1'b0;
        end else begin
          inst_valid <= 1'b1;
          inst_data  <= make_inst(dense);
        end
      end
    end

    while (commit_count < sent_count) @(posedge clk_in);
    // stray commits after the last one would show up here
    repeat (10) @(posedge clk_in);

    if (exp_rd_q.size() != 0) begin
      $display("%0d accepted instructions never committed", exp_rd_q.size());
      other_count++;
    end
    if (commit_count != sent_count) begin
      $display("%0d commits seen for %0d accepted instructions", commit_count, sent_count);
      other_count++;
    end
    if (!saw_stall) begin
      $display("inst_ready never dropped during the burst");
      other_count++;
    end
    if (dut.assert_checks.fail_count != 0) begin
      $display("%0d assertion failures in the bound checker", dut.assert_checks.fail_count);
      other_count++;
    end

    $display("errors: %0d mismatches, %0d other, %0d of %0d instructions committed",
             mismatch_count, other_count, commit_count, sent_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(TIMEOUT);
    $display("watchdog expired at %0t ns with %0d of %0d instructions committed",
             $time, commit_count, N_INST);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu import cpu_pkg::*; (
  input  logic    clk_in,
  input  logic    rst_in,
  input  logic    inst_valid,
  input  word_t   inst_data,
  output logic    inst_ready,
  output logic    commit_valid,
  output reg_id_t commit_rd,
  output word_t   commit_value
);

  logic     rs_full;
  logic     rob_full;
  rob_tag_t rob_alloc_tag;
  logic     rob_alloc;
  reg_id_t  rob_alloc_rd;
  reg_id_t  rf_rs1;
  reg_id_t  rf_rs2;
  reg_id_t  rf_rd;
  logic     rf_rename;
  word_t    rf_vj;
  word_t    rf_vk;
  logic     rf_qj_busy;
  logic     rf_qk_busy;
  rob_tag_t rf_qj;
  rob_tag_t rf_qk;
  logic     rob_j_done;
  logic     rob_k_done;
  word_t    rob_j_value;
  word_t    rob_k_value;
  logic     cdb_valid;
  rob_tag_t cdb_tag;
  word_t    cdb_value;

  dispatch_if dispatch_bus ();
  commit_if   commit_bus ();

  assign commit_valid = commit_bus.valid;

  issuer issuer_0 (
    .clk_in(clk_in), .rst_in(rst_in),
    .inst_valid(inst_valid), .inst_data(inst_data), .inst_ready(inst_ready),
    .rs_full(rs_full), .rob_full(rob_full), .rob_alloc_tag(rob_alloc_tag),
    .rf_rs1(rf_rs1), .rf_rs2(rf_rs2), .rf_rd(rf_rd), .rf_rename(rf_rename),
    .rf_vj(rf_vj), .rf_vk(rf_vk), .rf_qj_busy(rf_qj_busy), .rf_qk_busy(rf_qk_busy),
    .rf_qj(rf_qj), .rf_qk(rf_qk),
    .rob_alloc(rob_alloc), .rob_alloc_rd(rob_alloc_rd),
    .rob_j_done(rob_j_done), .rob_k_done(rob_k_done),
    .rob_j_value(rob_j_value), .rob_k_value(rob_k_value),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
    .dispatch(dispatch_bus.issue)
  );

  rs_station rs_station_0 (
    .clk_in(clk_in), .rst_in(rst_in),
    .dispatch(dispatch_bus.station), .rs_full(rs_full),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value)
  );

  // operand probes reuse the tags coming out of the register file
  ro_buffer ro_buffer_0 (
    .clk_in(clk_in), .rst_in(rst_in),
    .rob_alloc(rob_alloc), .rob_alloc_rd(rob_alloc_rd),
    .rob_full(rob_full), .rob_alloc_tag(rob_alloc_tag),
    .probe_qj(rf_qj), .probe_qk(rf_qk),
    .rob_j_done(rob_j_done), .rob_k_done(rob_k_done),
    .rob_j_value(rob_j_value), .rob_k_value(rob_k_value),
    .cdb_valid(cdb_valid), .cdb_tag(cdb_tag), .cdb_value(cdb_value),
    .commit_rd(commit_rd), .commit_value(commit_value),
    .retire(commit_bus.retire)
  );

  reg_file reg_file_0 (
    .clk_in(clk_in), .rst_in(rst_in),
    .rf_rs1(rf_rs1), .rf_rs2(rf_rs2),
    .rf_vj(rf_vj), .rf_vk(rf_vk), .rf_qj_busy(rf_qj_busy), .rf_qk_busy(rf_qk_busy),
    .rf_qj(rf_qj), .rf_qk(rf_qk),
    .rf_rd(rf_rd), .rf_rename(rf_rename), .rob_alloc_tag(rob_alloc_tag),
    .writeback(commit_bus.writeback)
  );

endmodule

`default_nettype wire

// ==== verilog/cpu_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// issuer to reservation station, one entry per strobe
interface dispatch_if import cpu_pkg::*;;
  logic     valid;
  rob_tag_t tag;
  alu_op_e  alu_op;
  word_t    vj;
  rob_tag_t qj;
  logic     qj_busy;
  word_t    vk;
  rob_tag_t qk;
  logic     qk_busy;

  modport issue (
    output valid, tag, alu_op, vj, qj, qj_busy, vk, qk, qk_busy
  );

  modport station (
    input valid, tag, alu_op, vj, qj, qj_busy, vk, qk, qk_busy
  );
endinterface

// in-order retirement into the register file
interface commit_if import cpu_pkg::*;;
  logic     valid;
  rob_tag_t tag;
  reg_id_t  rd;
  word_t    value;

  modport retire (
    output valid, tag, rd, value
  );

  modport writeback (
    input valid, tag, rd, value
  );
endinterface

`default_nettype wire

// ==== verilog/cpu_pkg.sv ====
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

  typedef logic [`CPU_XLEN-1:0] word_t;
  typedef logic [`CPU_REG_ID_W-1:0] reg_id_t;
  typedef logic [`CPU_ROB_TAG_W-1:0] rob_tag_t;

  // major opcodes kept in this core
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  typedef enum logic [1:0] {
    EMPTY,
    BUSY,
    DONE
  } rob_state_e;

endpackage

`default_nettype wire

// ==== verilog/issuer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module issuer import cpu_pkg::*; (
  input  logic     clk_in,
  input  logic     rst_in,
  input  logic     inst_valid,
  input  word_t    inst_data,
  output logic     inst_ready,
  input  logic     rs_full,
  input  logic     rob_full,
  input  rob_tag_t rob_alloc_tag,
  output reg_id_t  rf_rs1,
  output reg_id_t  rf_rs2,
  output reg_id_t  rf_rd,
  output logic     rf_rename,
  input  word_t    rf_vj,
  input  word_t    rf_vk,
  input  logic     rf_qj_busy,
  input  logic     rf_qk_busy,
  input  rob_tag_t rf_qj,
  input  rob_tag_t rf_qk,
  output logic     rob_alloc,
  output reg_id_t  rob_alloc_rd,
  input  logic     rob_j_done,
  input  logic     rob_k_done,
  input  word_t    rob_j_value,
  input  word_t    rob_k_value,
  input  logic     cdb_valid,
  input  rob_tag_t cdb_tag,
  input  word_t    cdb_value,
  dispatch_if.issue dispatch
);

  opcode_e  opcode;
  logic     is_imm;
  logic     accept;
  logic     ready_q;
  reg_id_t  rd;
  word_t    imm;
  alu_op_e  alu_op;
  word_t    vj;
  word_t    vk;
  rob_tag_t qj;
  rob_tag_t qk;
  logic     qj_busy;
  logic     qk_busy;

  // register value first, then a finished ROB entry, then the live broadcast
  function automatic void resolve(
    input  word_t    rf_value,
    input  logic     rf_busy,
    input  rob_tag_t rf_tag,
    input  logic     rob_done,
    input  word_t    rob_value,
    output word_t    value,
    output rob_tag_t tag,
    output logic     busy
  );
    value = rf_value;
    tag   = rf_tag;
    busy  = 1'b0;
    if (rf_busy) begin
      if (rob_done) begin
        value = rob_value;
      end else if (cdb_valid && cdb_tag == rf_tag) begin
        value = cdb_value;
      end else begin
        busy = 1'b1;
      end
    end
  endfunction

  // low until the first edge out of reset
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= 1'b1;
    end
  end

  assign inst_ready = ready_q && !rs_full && !rob_full;
  assign accept = inst_valid && inst_ready;

  assign opcode = opcode_e'(inst_data[6:0]);
  assign is_imm = (opcode == OP_IMM);
  assign rd     = inst_data[11:7];
  assign imm    = {{(`CPU_XLEN-12){inst_data[31]}}, inst_data[31:20]};

  always_comb begin
    case (inst_data[14:12])
      3'd0: alu_op = (opcode == OP && inst_data[30]) ? ALU_SUB : ALU_ADD;
      3'd1: alu_op = ALU_SLL;
      3'd2: alu_op = ALU_SLT;
      3'd3: alu_op = ALU_SLTU;
      3'd4: alu_op = ALU_XOR;
      3'd5: alu_op = inst_data[30] ? ALU_SRA : ALU_SRL;
      3'd6: alu_op = ALU_OR;
      default: alu_op = ALU_AND;
    endcase
  end

  always_comb begin
    resolve(rf_vj, rf_qj_busy, rf_qj, rob_j_done, rob_j_value, vj, qj, qj_busy);
    if (is_imm) begin
      vk      = imm;
      qk      = '0;
      qk_busy = 1'b0;
    end else begin
      resolve(rf_vk, rf_qk_busy, rf_qk, rob_k_done, rob_k_value, vk, qk, qk_busy);
    end
  end

  assign rf_rs1       = inst_data[19:15];
  assign rf_rs2       = inst_data[24:20];
  assign rf_rd        = rd;
  assign rf_rename    = accept && (rd != '0);
  assign rob_alloc    = accept;
  assign rob_alloc_rd = rd;

  assign dispatch.valid   = accept;
  assign dispatch.tag     = rob_alloc_tag;
  assign dispatch.alu_op  = alu_op;
  assign dispatch.vj      = vj;
  assign dispatch.qj      = qj;
  assign dispatch.qj_busy = qj_busy;
  assign dispatch.vk      = vk;
  assign dispatch.qk      = qk;
  assign dispatch.qk_busy = qk_busy;

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module reg_file import cpu_pkg::*; (
  input  logic     clk_in,
  input  logic     rst_in,
  input  reg_id_t  rf_rs1,
  input  reg_id_t  rf_rs2,
  output word_t    rf_vj,
  output word_t    rf_vk,
  output logic     rf_qj_busy,
  output logic     rf_qk_busy,
  output rob_tag_t rf_qj,
  output rob_tag_t rf_qk,
  input  reg_id_t  rf_rd,
  input  logic     rf_rename,
  input  rob_tag_t rob_alloc_tag,
  commit_if.writeback writeback
);

  localparam int COUNT = `CPU_REG_COUNT;

  word_t                values [COUNT];
  rob_tag_t             tags   [COUNT];
  logic [COUNT-1:0]     busy;

  assign rf_vj      = values[rf_rs1];
  assign rf_vk      = values[rf_rs2];
  assign rf_qj      = tags[rf_rs1];
  assign rf_qk      = tags[rf_rs2];
  assign rf_qj_busy = busy[rf_rs1];
  assign rf_qk_busy = busy[rf_rs2];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < COUNT; i++) begin
        values[i] <= '0;
        tags[i]   <= '0;
      end
      busy <= '0;
    end else begin
      if (writeback.valid && writeback.rd != '0) begin
        values[writeback.rd] <= writeback.value;
        // only the newest writer of rd frees it
        if (tags[writeback.rd] == writeback.tag) begin
          busy[writeback.rd] <= 1'b0;
        end
      end
      // a rename in the same cycle overrides the release above
      if (rf_rename) begin
        busy[rf_rd] <= 1'b1;
        tags[rf_rd] <= rob_alloc_tag;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/ro_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module ro_buffer import cpu_pkg::*; (
  input  logic     clk_in,
  input  logic     rst_in,
  input  logic     rob_alloc,
  input  reg_id_t  rob_alloc_rd,
  output logic     rob_full,
  output rob_tag_t rob_alloc_tag,
  input  rob_tag_t probe_qj,
  input  rob_tag_t probe_qk,
  output logic     rob_j_done,
  output logic     rob_k_done,
  output word_t    rob_j_value,
  output word_t    rob_k_value,
  input  logic     cdb_valid,
  input  rob_tag_t cdb_tag,
  input  word_t    cdb_value,
  output reg_id_t  commit_rd,
  output word_t    commit_value,
  commit_if.retire retire
);

  localparam int DEPTH = `CPU_ROB_DEPTH;

  rob_state_e state_q [DEPTH];
  reg_id_t    rd_q    [DEPTH];
  word_t      value_q [DEPTH];

  rob_tag_t                 head;
  rob_tag_t                 tail;
  logic [`CPU_ROB_TAG_W:0]  count;
  logic                     head_done;

  logic     commit_valid_q;
  rob_tag_t commit_tag_q;
  reg_id_t  commit_rd_q;
  word_t    commit_value_q;

  assign head_done     = (state_q[head] == DONE);
  assign rob_full      = (count == ($bits(count))'(DEPTH));
  assign rob_alloc_tag = tail;

  assign rob_j_done  = (state_q[probe_qj] == DONE);
  assign rob_k_done  = (state_q[probe_qk] == DONE);
  assign rob_j_value = value_q[probe_qj];
  assign rob_k_value = value_q[probe_qk];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < DEPTH; i++) begin
        state_q[i] <= EMPTY;
      end
      head           <= '0;
      tail           <= '0;
      count          <= '0;
      commit_valid_q <= 1'b0;
    end else begin
      // retired entry stays DONE until the register file has taken it
      if (commit_valid_q) begin
        state_q[commit_tag_q] <= EMPTY;
      end
      if (cdb_valid) begin
        state_q[cdb_tag] <= DONE;
      end
      if (rob_alloc) begin
        state_q[tail] <= BUSY;
        tail          <= tail + 1'b1;
      end
      if (head_done) begin
        head <= head + 1'b1;
      end
      commit_valid_q <= head_done;
      count <= count + {{`CPU_ROB_TAG_W{1'b0}}, rob_alloc}
                     - {{`CPU_ROB_TAG_W{1'b0}}, head_done};
    end
  end

  always_ff @(posedge clk_in) begin
    if (rob_alloc) begin
      rd_q[tail] <= rob_alloc_rd;
    end
    if (cdb_valid) begin
      value_q[cdb_tag] <= cdb_value;
    end
    // commit payload changes only when a commit is issued
    if (head_done) begin
      commit_tag_q   <= head;
      commit_rd_q    <= rd_q[head];
      commit_value_q <= value_q[head];
    end
  end

  assign retire.valid = commit_valid_q;
  assign retire.tag   = commit_tag_q;
  assign retire.rd    = commit_rd_q;
  assign retire.value = commit_value_q;

  assign commit_rd    = commit_rd_q;
  assign commit_value = commit_value_q;

endmodule

`default_nettype wire

// ==== verilog/rs_station.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cpu_params.svh"

module rs_station import cpu_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_in,
  dispatch_if.station dispatch,
  output logic       rs_full,
  output logic       cdb_valid,
  output rob_tag_t   cdb_tag,
  output word_t      cdb_value
);

  localparam int DEPTH = `CPU_RS_DEPTH;
  localparam int IDX_W = $clog2(DEPTH);

  logic [DEPTH-1:0] busy;
  rob_tag_t         tag_q     [DEPTH];
  alu_op_e          op_q      [DEPTH];
  word_t            vj_q      [DEPTH];
  word_t            vk_q      [DEPTH];
  rob_tag_t         qj_q      [DEPTH];
  rob_tag_t         qk_q      [DEPTH];
  logic             qj_busy_q [DEPTH];
  logic             qk_busy_q [DEPTH];

  logic [IDX_W-1:0] free_idx;
  logic [IDX_W-1:0] sel_idx;
  logic             sel_found;

  function automatic word_t alu(input alu_op_e op, input word_t a, input word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_SLL:  return a << b[4:0];
      ALU_SLT:  return word_t'($signed(a) < $signed(b));
      ALU_SLTU: return word_t'(a < b);
      ALU_XOR:  return a ^ b;
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return word_t'($signed(a) >>> b[4:0]);
      ALU_OR:   return a | b;
      default:  return a & b;
    endcase
  endfunction

  assign rs_full = &busy;

  // scan from the top so the lowest index wins
  always_comb begin
    free_idx  = '0;
    sel_idx   = '0;
    sel_found = 1'b0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!busy[i]) begin
        free_idx = IDX_W'(i);
      end
      if (busy[i] && !qj_busy_q[i] && !qk_busy_q[i]) begin
        sel_idx   = IDX_W'(i);
        sel_found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy      <= '0;
      cdb_valid <= 1'b0;
    end else begin
      if (sel_found) begin
        busy[sel_idx] <= 1'b0;
      end
      if (dispatch.valid) begin
        busy[free_idx] <= 1'b1;
      end
      cdb_valid <= sel_found;
    end
  end

  always_ff @(posedge clk_in) begin
    for (int i = 0; i < DEPTH; i++) begin
      // snoop the broadcast for waiting operands
      if (cdb_valid && busy[i] && qj_busy_q[i] && qj_q[i] == cdb_tag) begin
        vj_q[i]      <= cdb_value;
        qj_busy_q[i] <= 1'b0;
      end
      if (cdb_valid && busy[i] && qk_busy_q[i] && qk_q[i] == cdb_tag) begin
        vk_q[i]      <= cdb_value;
        qk_busy_q[i] <= 1'b0;
      end
    end
    if (dispatch.valid) begin
      tag_q[free_idx]     <= dispatch.tag;
      op_q[free_idx]      <= dispatch.alu_op;
      vj_q[free_idx]      <= dispatch.vj;
      vk_q[free_idx]      <= dispatch.vk;
      qj_q[free_idx]      <= dispatch.qj;
      qk_q[free_idx]      <= dispatch.qk;
      qj_busy_q[free_idx] <= dispatch.qj_busy;
      qk_busy_q[free_idx] <= dispatch.qk_busy;
    end
    cdb_tag   <= tag_q[sel_idx];
    cdb_value <= alu(op_q[sel_idx], vj_q[sel_idx], vk_q[sel_idx]);
  end

endmodule

`default_nettype wire
